/* flist.f */
+incdir+common
common/io_pkg.sv
src/io_port_check.sv
src/io_read_select.sv
src/io_write_strobe.sv
src/io_access_ctrl.sv
src/io_gate.sv
test/io_gate_tb.sv

/* Bender.yml */
package:
  name: io_gate

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/io_pkg.sv
      - src/io_port_check.sv
      - src/io_read_select.sv
      - src/io_write_strobe.sv
      - src/io_access_ctrl.sv
      - src/io_gate.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/io_gate_tb.sv

/* test/io_gate_tb.sv */
// ---------------------------------------------------------------------------
// Testbench of the I/O port gate
// Clock, reset, LFSR stimulus, reference model and checking assertions
// ---------------------------------------------------------------------------

`include "io_cfg.svh"

module io_gate_tb import io_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_BITS   = `IO_PORT_COUNT * `IO_WORD_WIDTH;
    localparam int RUN_CYCLES  = 600;
    localparam int DRAIN_LIMIT = 16;

    // Expected outcome of one instruction
    typedef struct packed {
        logic       issued;
        logic       rd_io;
        logic       wr_io;
        logic       done;
        logic       annul;
        port_bits_t rd_ack;
        word_t      rd_data;
        port_bits_t wr_en;
        word_t      wr_data;
    } outcome_t;

    logic                 clock;
    logic                 arst_n;
    logic                 issue;
    addr_t                rd_addr;
    addr_t                wr_addr;
    word_t                wr_data;
    logic                 done;
    logic                 annul;
    port_bits_t           rd_port_ef;
    logic [DATA_BITS-1:0] rd_port_data;
    logic                 rd_valid;
    word_t                rd_data;
    port_bits_t           rd_ack;
    port_bits_t           wr_port_ef;
    port_bits_t           wr_en;
    word_t                wr_data_out;

    // Index 0 is one cycle old, index 1 is due at the DUT outputs
    outcome_t    exp_pipe [0:1];
    logic [31:0] lfsr_state;
    int          issued_count;
    int          outcome_count;
    int          done_count;
    int          annul_count;
    int          mismatch_count;
    int          other_count;
    int          mem_hits;
    int          rd_hits;
    int          wr_hits;
    int          both_io_hits;
    int          annul_hits;
    int          b2b_hits;
    bit          timed_out;

    io_gate io_gate_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue        (issue),
        .rd_addr      (rd_addr),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .done         (done),
        .annul        (annul),
        .rd_port_ef   (rd_port_ef),
        .rd_port_data (rd_port_data),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_ack       (rd_ack),
        .wr_port_ef   (wr_port_ef),
        .wr_en        (wr_en),
        .wr_data_out  (wr_data_out)
    );

    // 8 ns period
    always #4 clock = ~clock;

    // -------------------------------------------------------------------------
    // Random source
    // -------------------------------------------------------------------------

    // Galois form, right shift, maximal length taps
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int count, output logic [DATA_BITS-1:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value      = {value[DATA_BITS-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Half inside the window, the rest on the edges just outside or anywhere
    task automatic pick_addr(input addr_t base, output addr_t addr);
        logic [DATA_BITS-1:0] bits;
        draw_bits(1, bits);
        if (bits[0]) begin
            draw_bits(2, bits);
            addr = base + addr_t'(bits[1:0]);
        end else begin
            draw_bits(2, bits);
            case (bits[1:0])
                2'd0:    addr = base - addr_t'(1);
                2'd1:    addr = base + addr_t'(`IO_PORT_COUNT);
                default: begin
                    draw_bits(`IO_ADDR_WIDTH, bits);
                    addr = addr_t'(bits);
                end
            endcase
        end
    endtask

    // Issue high about three cycles in four
    task automatic drive_random();
        logic [DATA_BITS-1:0] bits;
        addr_t                ra;
        addr_t                wa;
        draw_bits(2, bits);
        issue <= |bits[1:0];
        pick_addr(`IO_RD_BASE, ra);
        pick_addr(`IO_WR_BASE, wa);
        rd_addr <= ra;
        wr_addr <= wa;
        draw_bits(`IO_PORT_COUNT, bits);
        rd_port_ef <= port_bits_t'(bits);
        draw_bits(`IO_PORT_COUNT, bits);
        wr_port_ef <= port_bits_t'(bits);
        draw_bits(DATA_BITS, bits);
        rd_port_data <= bits;
        draw_bits(`IO_WORD_WIDTH, bits);
        wr_data <= word_t'(bits);
    endtask

    // -------------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------------

    function automatic logic in_window(input addr_t addr, input addr_t base);
        return (int'(addr) >= int'(base)) && (int'(addr) <= int'(base) + `IO_PORT_COUNT - 1);
    endfunction

    function automatic outcome_t predict(
        input logic iss, input addr_t ra, input addr_t wa, input port_bits_t rd_ef,
        input port_bits_t wr_ef, input logic [DATA_BITS-1:0] pdata, input word_t wd
    );
        outcome_t  o;
        port_idx_t ri;
        port_idx_t wi;
        logic      rd_ok;
        logic      wr_ok;
        o        = '0;
        o.issued = iss;
        o.rd_io  = iss && in_window(ra, `IO_RD_BASE);
        o.wr_io  = iss && in_window(wa, `IO_WR_BASE);
        ri       = port_idx_t'(ra - `IO_RD_BASE);
        wi       = port_idx_t'(wa - `IO_WR_BASE);
        // Memory addresses are always ready, reads want full, writes want empty
        rd_ok    = !o.rd_io || rd_ef[ri];
        wr_ok    = !o.wr_io || !wr_ef[wi];
        o.done   = iss && rd_ok && wr_ok;
        o.annul  = iss && !o.done;
        if (o.done && o.rd_io) begin
            o.rd_ack[ri] = 1'b1;
            o.rd_data    = pdata[ri*`IO_WORD_WIDTH +: `IO_WORD_WIDTH];
        end
        if (o.done && o.wr_io) begin
            o.wr_en[wi] = 1'b1;
            o.wr_data   = wd;
        end
        return o;
    endfunction

    // Two instructions in flight at most
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            exp_pipe[0] <= '0;
            exp_pipe[1] <= '0;
        end else begin
            exp_pipe[1] <= exp_pipe[0];
            exp_pipe[0] <= predict(issue, rd_addr, wr_addr, rd_port_ef, wr_port_ef,
                                   rd_port_data, wr_data);
            if (issue) begin
                issued_count <= issued_count + 1;
            end
        end
    end

    // Outcome counts and stimulus reach
    always @(posedge clock) begin
        if (arst_n) begin
            outcome_count <= outcome_count + int'(done || annul);
            done_count    <= done_count + int'(done);
            annul_count   <= annul_count + int'(annul);
            if (exp_pipe[1].issued) begin
                mem_hits     <= mem_hits + int'(!exp_pipe[1].rd_io && !exp_pipe[1].wr_io);
                rd_hits      <= rd_hits + int'(exp_pipe[1].rd_ack != '0);
                wr_hits      <= wr_hits + int'(exp_pipe[1].wr_en != '0);
                both_io_hits <= both_io_hits + int'(exp_pipe[1].rd_io && exp_pipe[1].wr_io);
                annul_hits   <= annul_hits + int'(exp_pipe[1].annul);
                b2b_hits     <= b2b_hits + int'(exp_pipe[0].issued);
            end
        end
    end

    // -------------------------------------------------------------------------
    // Output checks, two edges after the issue edge
    // -------------------------------------------------------------------------

    a_done : assert property (@(posedge clock) disable iff (!arst_n)
        done == exp_pipe[1].done)
    else begin
        mismatch_count++;
        $display("[FAIL] done expected %h got %h", $sampled(exp_pipe[1].done), $sampled(done));
    end

    a_annul : assert property (@(posedge clock) disable iff (!arst_n)
        annul == exp_pipe[1].annul)
    else begin
        mismatch_count++;
        $display("[FAIL] annul expected %h got %h", $sampled(exp_pipe[1].annul),
                 $sampled(annul));
    end

    a_rd_valid : assert property (@(posedge clock) disable iff (!arst_n)
        rd_valid == (exp_pipe[1].rd_ack != '0))
    else begin
        mismatch_count++;
        $display("[FAIL] rd_valid expected %h got %h", $sampled(exp_pipe[1].rd_ack != '0),
                 $sampled(rd_valid));
    end

    a_rd_ack : assert property (@(posedge clock) disable iff (!arst_n)
        rd_ack == exp_pipe[1].rd_ack)
    else begin
        mismatch_count++;
        $display("[FAIL] rd_ack expected %h got %h", $sampled(exp_pipe[1].rd_ack),
                 $sampled(rd_ack));
    end

    a_rd_data : assert property (@(posedge clock) disable iff (!arst_n)
        (exp_pipe[1].rd_ack != '0) |-> (rd_data == exp_pipe[1].rd_data))
    else begin
        mismatch_count++;
        $display("[FAIL] rd_data expected %h got %h", $sampled(exp_pipe[1].rd_data),
                 $sampled(rd_data));
    end

    a_wr_en : assert property (@(posedge clock) disable iff (!arst_n)
        wr_en == exp_pipe[1].wr_en)
    else begin
        mismatch_count++;
        $display("[FAIL] wr_en expected %h got %h", $sampled(exp_pipe[1].wr_en),
                 $sampled(wr_en));
    end

    a_wr_data_out : assert property (@(posedge clock) disable iff (!arst_n)
        (exp_pipe[1].wr_en != '0) |-> (wr_data_out == exp_pipe[1].wr_data))
    else begin
        mismatch_count++;
        $display("[FAIL] wr_data_out expected %h got %h", $sampled(exp_pipe[1].wr_data),
                 $sampled(wr_data_out));
    end

    // Nothing may come out of a cycle without an instruction behind it
    a_no_orphan : assert property (@(posedge clock) disable iff (!arst_n)
        !exp_pipe[1].issued |-> !(done || annul || rd_valid) && rd_ack == '0 && wr_en == '0)
    else begin
        other_count++;
        $display("outcome seen although issue was low two cycles earlier");
    end

    // -------------------------------------------------------------------------
    // Sequence
    // -------------------------------------------------------------------------

    // Counters are read off the falling edge where they are stable
    task automatic wait_for_outcomes(output bit expired);
        int waited;
        expired = 1'b1;
        for (waited = 0; waited < DRAIN_LIMIT && expired; waited++) begin
            @(negedge clock);
            if (outcome_count == issued_count) begin
                expired = 1'b0;
            end
        end
    endtask

    task automatic require_hit(input int hits, input string what);
        if (hits == 0) begin
            other_count++;
            $display("stimulus never reached %s", what);
        end
    endtask

    initial begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        issue        = 1'b0;
        rd_addr      = '0;
        wr_addr      = '0;
        wr_data      = '0;
        rd_port_ef   = '0;
        wr_port_ef   = '0;
        rd_port_data = '0;
        lfsr_state   = 32'h34bf_55d2;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        // Idle stretch right after reset
        repeat (4) @(posedge clock);
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clock);
            drive_random();
        end
        @(posedge clock);
        issue <= 1'b0;
        wait_for_outcomes(timed_out);
        if (timed_out) begin
            other_count++;
            $display("timeout, %0d issued but only %0d outcomes seen", issued_count,
                     outcome_count);
        end
        require_hit(mem_hits, "a memory only instruction");
        require_hit(rd_hits, "an accepted port read");
        require_hit(wr_hits, "an accepted port write");
        require_hit(both_io_hits, "a read and a write port in one instruction");
        require_hit(annul_hits, "an annulled instruction");
        require_hit(b2b_hits, "back to back issues");
        $display("issued %0d done %0d annulled %0d mismatches %0d other errors %0d",
                 issued_count, done_count, annul_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/io_gate.sv */
// ---------------------------------------------------------------------------
// Top level of the I/O port gate
// Read and write port checks, access control and both datapath blocks
// ---------------------------------------------------------------------------

`include "io_cfg.svh"

module io_gate import io_pkg::*; (
    input  logic                                       clock,
    input  logic                                       arst_n,
    // Core side
    input  logic                                       issue,
    input  addr_t                                      rd_addr,
    input  addr_t                                      wr_addr,
    input  word_t                                      wr_data,
    output logic                                       done,
    output logic                                       annul,
    // Read ports
    input  port_bits_t                                 rd_port_ef,
    input  logic [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0]   rd_port_data,
    output logic                                       rd_valid,
    output word_t                                      rd_data,
    output port_bits_t                                 rd_ack,
    // Write ports
    input  port_bits_t                                 wr_port_ef,
    output port_bits_t                                 wr_en,
    output word_t                                      wr_data_out
);

    logic      rd_ready;
    logic      rd_is_io;
    port_idx_t rd_idx;
    logic      wr_ready;
    logic      wr_is_io;
    port_idx_t wr_idx;
    logic      rd_take;
    logic      wr_take;

    // -------------------------------------------------------------------------
    // Port checks
    // -------------------------------------------------------------------------

    // Reads need a full port
    io_port_check #(
        .READY_STATE (1'b1),
        .PORT_BASE   (`IO_RD_BASE)
    ) rd_check (
        .clock    (clock),
        .arst_n   (arst_n),
        .enable   (issue),
        .addr     (rd_addr),
        .port_ef  (rd_port_ef),
        .ready    (rd_ready),
        .is_io    (rd_is_io),
        .port_idx (rd_idx)
    );

    // Writes need an empty port
    io_port_check #(
        .READY_STATE (1'b0),
        .PORT_BASE   (`IO_WR_BASE)
    ) wr_check (
        .clock    (clock),
        .arst_n   (arst_n),
        .enable   (issue),
        .addr     (wr_addr),
        .port_ef  (wr_port_ef),
        .ready    (wr_ready),
        .is_io    (wr_is_io),
        .port_idx (wr_idx)
    );

    // -------------------------------------------------------------------------
    // Control and datapath
    // -------------------------------------------------------------------------

    io_access_ctrl access_ctrl (
        .clock    (clock),
        .arst_n   (arst_n),
        .issue    (issue),
        .rd_ready (rd_ready),
        .rd_is_io (rd_is_io),
        .wr_ready (wr_ready),
        .wr_is_io (wr_is_io),
        .done     (done),
        .annul    (annul),
        .rd_take  (rd_take),
        .wr_take  (wr_take)
    );

    io_read_select read_select (
        .clock        (clock),
        .arst_n       (arst_n),
        .port_idx     (rd_idx),
        .rd_port_data (rd_port_data),
        .rd_take      (rd_take),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_ack       (rd_ack)
    );

    io_write_strobe write_strobe (
        .clock       (clock),
        .arst_n      (arst_n),
        .wr_data     (wr_data),
        .port_idx    (wr_idx),
        .wr_take     (wr_take),
        .wr_en       (wr_en),
        .wr_data_out (wr_data_out)
    );

endmodule

/* src/io_access_ctrl.sv */
// ---------------------------------------------------------------------------
// Access control of the I/O port gate
// Combines both ready bits into done, annul and the datapath take pulses
// ---------------------------------------------------------------------------

module io_access_ctrl import io_pkg::*; (
    input  logic clock,
    input  logic arst_n,
    input  logic issue,
    input  logic rd_ready,
    input  logic rd_is_io,
    input  logic wr_ready,
    input  logic wr_is_io,
    output logic done,
    output logic annul,
    output logic rd_take,
    output logic wr_take
);

    logic issue_q;
    logic go;

    // -------------------------------------------------------------------------
    // Issue pipeline
    // -------------------------------------------------------------------------

    // Lines up with the ready bits out of the port checks
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= issue;
        end
    end

    // Both sides must agree before anything moves
    assign go = issue_q && rd_ready && wr_ready;

    // -------------------------------------------------------------------------
    // Outcome registers
    // -------------------------------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done    <= 1'b0;
            annul   <= 1'b0;
            rd_take <= 1'b0;
            wr_take <= 1'b0;
        end else begin
            done    <= go;
            // Issued but blocked so the core reissues it
            annul   <= issue_q && !go;
            // Memory side accesses need no port action
            rd_take <= go && rd_is_io;
            wr_take <= go && wr_is_io;
        end
    end

    // An instruction ends exactly one way
    a_done_annul_excl : assert property (
        @(posedge clock) disable iff (!arst_n) !(done && annul)
    );

    // A port is consumed only by a finished instruction
    a_rd_take_done : assert property (
        @(posedge clock) disable iff (!arst_n) rd_take |-> done
    );

endmodule

/* src/io_write_strobe.sv */
// ---------------------------------------------------------------------------
// Write side datapath
// Write word delay line and one-hot write enable decode
// ---------------------------------------------------------------------------

module io_write_strobe import io_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  word_t      wr_data,
    input  port_idx_t  port_idx,
    input  logic       wr_take,
    output port_bits_t wr_en,
    output word_t      wr_data_out
);

    word_t      data_s1;
    port_idx_t  idx_s2;
    port_bits_t en_onehot;

    // -------------------------------------------------------------------------
    // Delay line
    // -------------------------------------------------------------------------

    // Word captured at the issue edge
    always_ff @(posedge clock) begin
        data_s1 <= wr_data;
    end

    // Second stage matches the decision latency of the control
    // Index comes in one cycle after issue from the write port check
    always_ff @(posedge clock) begin
        wr_data_out <= data_s1;
        idx_s2      <= port_idx;
    end

    // -------------------------------------------------------------------------
    // Write enable
    // -------------------------------------------------------------------------

    always_comb begin
        en_onehot         = '0;
        en_onehot[idx_s2] = 1'b1;
    end

    // Strobe only the written port, and only on an accepted write
    assign wr_en = wr_take ? en_onehot : '0;

    // Never more than one port written at a time
    a_wr_en_onehot : assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(wr_en)
    );

endmodule

/* src/io_read_select.sv */
// ---------------------------------------------------------------------------
// Read side datapath
// Port data sample, selected word register and one-hot read acknowledge
// ---------------------------------------------------------------------------

`include "io_cfg.svh"

module io_read_select import io_pkg::*; (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  port_idx_t                                  port_idx,
    input  logic [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0]   rd_port_data,
    input  logic                                       rd_take,
    output logic                                       rd_valid,
    output word_t                                      rd_data,
    output port_bits_t                                 rd_ack
);

    logic [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0] data_s1;
    word_t                                    word_sel;
    port_idx_t                                idx_s2;
    port_bits_t                               ack_onehot;

    // -------------------------------------------------------------------------
    // Data path
    // -------------------------------------------------------------------------

    // All port words as they stood at the issue edge
    always_ff @(posedge clock) begin
        data_s1 <= rd_port_data;
    end

    // Index arrives already registered from the read port check
    assign word_sel = data_s1[port_idx*`IO_WORD_WIDTH +: `IO_WORD_WIDTH];

    // Word and index line up with the take pulse from the control
    always_ff @(posedge clock) begin
        rd_data <= word_sel;
        idx_s2  <= port_idx;
    end

    // -------------------------------------------------------------------------
    // Acknowledge
    // -------------------------------------------------------------------------

    always_comb begin
        ack_onehot         = '0;
        ack_onehot[idx_s2] = 1'b1;
    end

    // Only the consumed port sees its acknowledge
    assign rd_ack   = rd_take ? ack_onehot : '0;
    assign rd_valid = rd_take;

    // At most one read port consumed per instruction
    a_rd_ack_onehot : assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(rd_ack)
    );

endmodule

/* src/io_port_check.sv */
// ---------------------------------------------------------------------------
// Port window check shared by the read and the write side
// Two-stage address window decode, empty/full bit select and ready mask
// ---------------------------------------------------------------------------

`include "io_cfg.svh"

module io_port_check import io_pkg::*; #(
    // Empty/full value that means ready, 1 for reads and 0 for writes
    parameter logic  READY_STATE = 1'b1,
    // First address of the port window
    parameter addr_t PORT_BASE   = `IO_RD_BASE
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       enable,
    input  addr_t      addr,
    input  port_bits_t port_ef,
    output logic       ready,
    output logic       is_io,
    output port_idx_t  port_idx
);

    // Last address inside the window
    localparam addr_t PORT_BOUND = PORT_BASE + addr_t'(`IO_PORT_COUNT - 1);

    // Value seen by a check that is switched off
    localparam logic NOT_READY = ~READY_STATE;

    addr_t     addr_offset;
    port_idx_t idx_raw;
    logic      hit_raw;
    logic      ef_sel_q;
    logic      enable_q;
    logic      ef_masked;

    // -------------------------------------------------------------------------
    // Stage 1, sampled at the issue edge
    // -------------------------------------------------------------------------

    // Offset into the window, only the low bits matter inside it
    assign addr_offset = addr - PORT_BASE;
    assign idx_raw     = addr_offset[`IO_PORT_IDX_WIDTH-1:0];

    // Window hit only counts while an instruction is issued
    assign hit_raw = enable && (addr >= PORT_BASE) && (addr <= PORT_BOUND);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= 1'b0;
            is_io    <= 1'b0;
        end else begin
            enable_q <= enable;
            is_io    <= hit_raw;
        end
    end

    // Selected empty/full bit and index travel without reset
    always_ff @(posedge clock) begin
        ef_sel_q <= port_ef[idx_raw];
        port_idx <= idx_raw;
    end

    // -------------------------------------------------------------------------
    // Stage 2, masking into ready
    // -------------------------------------------------------------------------

    // Memory addresses look like a port in the ready state
    always_comb begin
        if (!enable_q) begin
            ef_masked = NOT_READY;
        end else if (!is_io) begin
            ef_masked = READY_STATE;
        end else begin
            ef_masked = ef_sel_q;
        end
    end

    assign ready = (ef_masked == READY_STATE);

    // Window hit must come from an issued instruction
    a_is_io_enabled : assert property (
        @(posedge clock) disable iff (!arst_n) is_io |-> enable_q
    );

endmodule

/* common/io_pkg.sv */
// ---------------------------------------------------------------------------
// Shared types of the I/O port gate
// Addresses, data words, port indexes and per-port bit vectors
// ---------------------------------------------------------------------------

`include "io_cfg.svh"

package io_pkg;

    // -------------------------------------------------------------------------
    // Address and data
    // -------------------------------------------------------------------------

    // Read or write address as issued by the core
    typedef logic [`IO_ADDR_WIDTH-1:0] addr_t;

    // One port data word
    typedef logic [`IO_WORD_WIDTH-1:0] word_t;

    // -------------------------------------------------------------------------
    // Port selection
    // -------------------------------------------------------------------------

    // Offset of a port from the base of its window
    typedef logic [`IO_PORT_IDX_WIDTH-1:0] port_idx_t;

    // One bit per port
    // Used for empty/full bits, read acknowledges and write enables
    typedef logic [`IO_PORT_COUNT-1:0] port_bits_t;

endpackage

/* common/io_cfg.svh */
// ---------------------------------------------------------------------------
// Configuration macros for the I/O port gate
// Address and word widths, port count and the two port window bases
// ---------------------------------------------------------------------------

`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// Width of the read and write addresses
`define IO_ADDR_WIDTH 10

// Width of one port data word
`define IO_WORD_WIDTH 16

// Number of read ports, same count of write ports
`define IO_PORT_COUNT 4

// Width of a port index inside its window
`define IO_PORT_IDX_WIDTH 2

// First address of the read port window
`define IO_RD_BASE 10'h3F0

// First address of the write port window
`define IO_WR_BASE 10'h3F8

`endif
